// File: include/core_params.svh
// architectural widths and register count macros
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// register and datapath width
`define XLEN 32

// program counter width, narrower than xlen
`define PC_WIDTH 16

// architectural integer registers
`define REG_COUNT 32

`endif

// File: source/core_pkg.sv
// opcode, alu operation and branch condition enums, instruction views and union
package core_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // same encodings as the branch funct3 field
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_view_t;

    // one instruction word, two field layouts
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

endpackage

// File: source/decoder.sv
// instruction decoder, operand select and decode-to-execute stage register
`timescale 1ns/1ps
`include "core_params.svh"

module decoder import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 instr_valid_i,
    input  instr_u               instr_i,
    input  logic [`PC_WIDTH-1:0] pc_i,
    input  logic [`XLEN-1:0]     rs1_data_i,
    input  logic [`XLEN-1:0]     rs2_data_i,
    output logic [4:0]           rs1_addr_o,
    output logic [4:0]           rs2_addr_o,
    output logic                 ex_valid_o,
    output alu_op_t              alu_op_o,
    output logic [`XLEN-1:0]     operand_a_o,
    output logic [`XLEN-1:0]     operand_b_o,
    output branch_cond_t         branch_cond_o,
    output logic                 is_branch_o,
    output logic                 is_jalr_o,
    output logic [`PC_WIDTH-1:0] branch_offset_o,
    output logic [`XLEN-1:0]     rs1_value_o,
    output logic [`XLEN-1:0]     rs2_value_o,
    output logic [`PC_WIDTH-1:0] ex_pc_o,
    output logic [4:0]           ex_rd_o,
    output logic                 ex_reg_write_o
);

    alu_op_t                alu_op_d;
    logic                   is_branch_d;
    logic                   is_jalr_d;
    logic                   use_imm;
    logic                   writes_rd;
    logic [`XLEN-1:0]       imm_i;
    logic [12:0]            b_imm;
    logic [`PC_WIDTH-1:0]   br_off;

    assign rs1_addr_o = instr_i.r.rs1; // register reads straight from the word
    assign rs2_addr_o = instr_i.r.rs2;

    assign imm_i = {{(`XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};

    // b-type offset is scattered over the funct7 and rd slots
    assign b_imm  = {instr_i.r.funct7[6], instr_i.r.rd[0], instr_i.r.funct7[5:0],
                     instr_i.r.rd[4:1], 1'b0};
    assign br_off = {{(`PC_WIDTH-13){b_imm[12]}}, b_imm};

    always_comb begin
        alu_op_d    = ALU_ADD; // jalr and branches just use add
        is_branch_d = 1'b0;
        is_jalr_d   = 1'b0;
        use_imm     = 1'b0;
        writes_rd   = 1'b0;
        case (instr_i.r.opcode)
            OPC_OP, OPC_OP_IMM: begin
                writes_rd = 1'b1;
                use_imm   = (instr_i.r.opcode == OPC_OP_IMM);
                case (instr_i.r.funct3)
                    3'b000:  alu_op_d = (!use_imm && instr_i.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op_d = ALU_SLL;
                    3'b010:  alu_op_d = ALU_SLT;
                    3'b011:  alu_op_d = ALU_SLTU;
                    3'b100:  alu_op_d = ALU_XOR;
                    3'b101:  alu_op_d = instr_i.r.funct7[5] ? ALU_SRA : ALU_SRL; // srai too
                    3'b110:  alu_op_d = ALU_OR;
                    default: alu_op_d = ALU_AND;
                endcase
            end
            OPC_BRANCH: is_branch_d = 1'b1;
            OPC_JALR: begin
                is_jalr_d = 1'b1;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            default: ; // unknown opcode, no write and no jump
        endcase
    end

    // decode/execute stage register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_valid_o      <= 1'b0;
            alu_op_o        <= ALU_ADD;
            operand_a_o     <= '0;
            operand_b_o     <= '0;
            branch_cond_o   <= BR_EQ;
            is_branch_o     <= 1'b0;
            is_jalr_o       <= 1'b0;
            branch_offset_o <= '0;
            rs1_value_o     <= '0;
            rs2_value_o     <= '0;
            ex_pc_o         <= '0;
            ex_rd_o         <= '0;
            ex_reg_write_o  <= 1'b0;
        end else if (instr_valid_i) begin
            ex_valid_o      <= 1'b1;
            alu_op_o        <= alu_op_d;
            operand_a_o     <= rs1_data_i;
            operand_b_o     <= use_imm ? imm_i : rs2_data_i;
            branch_cond_o   <= branch_cond_t'(instr_i.r.funct3);
            is_branch_o     <= is_branch_d;
            is_jalr_o       <= is_jalr_d;
            branch_offset_o <= br_off;
            rs1_value_o     <= rs1_data_i;
            rs2_value_o     <= rs2_data_i;
            ex_pc_o         <= pc_i;
            ex_rd_o         <= instr_i.r.rd;
            ex_reg_write_o  <= writes_rd && (instr_i.r.rd != 5'd0); // x0 never written
        end else begin
            ex_valid_o      <= 1'b0; // payload holds, only valid drops
        end
    end

endmodule

// File: source/reg_file.sv
// integer register file with x0 tied to zero and write-through read bypass
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [4:0]       rs1_addr_i,
    input  logic [4:0]       rs2_addr_i,
    input  logic             we_i,
    input  logic [4:0]       rd_i,
    input  logic [`XLEN-1:0] wd_i,
    output logic [`XLEN-1:0] rs1_data_o,
    output logic [`XLEN-1:0] rs2_data_o
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int k = 0; k < `REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wd_i;
        end
    end

    // a read of the register being written sees the new value
    always_comb begin
        if (rs1_addr_i == 5'd0)
            rs1_data_o = '0;
        else if (we_i && rd_i == rs1_addr_i)
            rs1_data_o = wd_i; // bypass
        else
            rs1_data_o = regs[rs1_addr_i];
    end

    always_comb begin
        if (rs2_addr_i == 5'd0)
            rs2_data_o = '0;
        else if (we_i && rd_i == rs2_addr_i)
            rs2_data_o = wd_i;
        else
            rs2_data_o = regs[rs2_addr_i];
    end

endmodule

// File: source/alu.sv
// combinational integer alu, arithmetic, logic, compare and shifts
`timescale 1ns/1ps
`include "core_params.svh"

module alu import core_pkg::*; (
    input  alu_op_t          alu_op_i,
    input  logic [`XLEN-1:0] operand_a_i,
    input  logic [`XLEN-1:0] operand_b_i,
    output logic [`XLEN-1:0] result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = operand_b_i[4:0]; // only low five bits shift
    assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign lt_unsigned = operand_a_i < operand_b_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:
                result_o = operand_a_i + operand_b_i;
            ALU_SUB:
                result_o = operand_a_i - operand_b_i;
            ALU_SLL:
                result_o = operand_a_i << shamt;
            ALU_SLT:
                result_o = {{(`XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:
                result_o = {{(`XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:
                result_o = operand_a_i ^ operand_b_i;
            ALU_SRL:
                result_o = operand_a_i >> shamt;
            ALU_SRA:
                result_o = $unsigned($signed(operand_a_i) >>> shamt); // keeps the sign
            ALU_OR:
                result_o = operand_a_i | operand_b_i;
            ALU_AND:
                result_o = operand_a_i & operand_b_i;
            default:
                result_o = '0;
        endcase
    end

endmodule

// File: source/branch_tester.sv
// branch condition check and branch target adder
`timescale 1ns/1ps
`include "core_params.svh"

module branch_tester import core_pkg::*; (
    input  branch_cond_t         branch_cond_i,
    input  logic [`XLEN-1:0]     rs1_value_i,
    input  logic [`XLEN-1:0]     rs2_value_i,
    input  logic [`PC_WIDTH-1:0] pc_i,
    input  logic [`PC_WIDTH-1:0] branch_offset_i,
    output logic                 taken_o,
    output logic [`PC_WIDTH-1:0] target_o
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = rs1_value_i == rs2_value_i;
    assign lt  = $signed(rs1_value_i) < $signed(rs2_value_i);
    assign ltu = rs1_value_i < rs2_value_i;

    always_comb begin
        case (branch_cond_i)
            BR_EQ:   taken_o = eq;
            BR_NE:   taken_o = !eq;
            BR_LT:   taken_o = lt;
            BR_GE:   taken_o = !lt;
            BR_LTU:  taken_o = ltu;
            BR_GEU:  taken_o = !ltu;
            default: taken_o = 1'b0; // funct3 010/011 are not branches
        endcase
    end

    assign target_o = pc_i + branch_offset_i; // wraps at pc width

endmodule

// File: source/writeback.sv
// writeback select for register write and jump, plus the output register
`timescale 1ns/1ps
`include "core_params.svh"

module writeback (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 ex_valid_i,
    input  logic                 is_branch_i,
    input  logic                 is_jalr_i,
    input  logic [4:0]           ex_rd_i,
    input  logic                 ex_reg_write_i,
    input  logic [`PC_WIDTH-1:0] ex_pc_i,
    input  logic [`XLEN-1:0]     alu_result_i,
    input  logic                 taken_i,
    input  logic [`PC_WIDTH-1:0] branch_target_i,
    output logic                 rf_we_o,
    output logic [4:0]           rf_rd_o,
    output logic [`XLEN-1:0]     rf_wd_o,
    output logic                 wb_valid_o,
    output logic                 wb_we_o,
    output logic [4:0]           wb_rd_o,
    output logic [`XLEN-1:0]     wb_data_o,
    output logic                 jump_o,
    output logic [`PC_WIDTH-1:0] jump_target_o
);

    logic [`PC_WIDTH-1:0] link_pc;
    logic                 jump_d;
    logic [`PC_WIDTH-1:0] target_d;

    assign link_pc = ex_pc_i + `PC_WIDTH'd4;

    // register file write port, same cycle as execute
    assign rf_we_o = ex_valid_i && ex_reg_write_i;
    assign rf_rd_o = ex_rd_i;
    assign rf_wd_o = is_jalr_i ? {{(`XLEN-`PC_WIDTH){1'b0}}, link_pc} : alu_result_i;

    assign jump_d   = ex_valid_i && (is_jalr_i || (is_branch_i && taken_i));
    assign target_d = is_jalr_i ? {alu_result_i[`PC_WIDTH-1:1], 1'b0} // rs1+imm, lsb cleared
                                : branch_target_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o    <= 1'b0;
            wb_we_o       <= 1'b0;
            wb_rd_o       <= '0;
            wb_data_o     <= '0;
            jump_o        <= 1'b0;
            jump_target_o <= '0;
        end else begin
            wb_valid_o    <= ex_valid_i; // one pulse per instruction
            wb_we_o       <= rf_we_o;
            wb_rd_o       <= rf_rd_o;
            wb_data_o     <= rf_wd_o;
            jump_o        <= jump_d;
            jump_target_o <= target_d;
        end
    end

endmodule

// File: source/core_top.sv
// core top level, decoder, register file, alu, branch tester and writeback
`timescale 1ns/1ps
`include "core_params.svh"

module core_top import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 instr_valid_i,
    input  instr_u               instr_i,
    input  logic [`PC_WIDTH-1:0] pc_i,
    output logic                 wb_valid_o,
    output logic                 wb_we_o,
    output logic [4:0]           wb_rd_o,
    output logic [`XLEN-1:0]     wb_data_o,
    output logic                 jump_o,
    output logic [`PC_WIDTH-1:0] jump_target_o
);

    // decode side
    logic [4:0]           rs1_addr;
    logic [4:0]           rs2_addr;
    logic [`XLEN-1:0]     rs1_data;
    logic [`XLEN-1:0]     rs2_data;

    // execute stage
    logic                 ex_valid;
    alu_op_t              alu_op;
    logic [`XLEN-1:0]     operand_a;
    logic [`XLEN-1:0]     operand_b;
    branch_cond_t         branch_cond;
    logic                 is_branch;
    logic                 is_jalr;
    logic [`PC_WIDTH-1:0] branch_offset;
    logic [`XLEN-1:0]     rs1_value;
    logic [`XLEN-1:0]     rs2_value;
    logic [`PC_WIDTH-1:0] ex_pc;
    logic [4:0]           ex_rd;
    logic                 ex_reg_write;

    logic [`XLEN-1:0]     alu_result;
    logic                 branch_taken;
    logic [`PC_WIDTH-1:0] branch_target;

    // register file write port
    logic                 rf_we;
    logic [4:0]           rf_rd;
    logic [`XLEN-1:0]     rf_wd;

    decoder u_decoder (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .ex_valid_o      (ex_valid),
        .alu_op_o        (alu_op),
        .operand_a_o     (operand_a),
        .operand_b_o     (operand_b),
        .branch_cond_o   (branch_cond),
        .is_branch_o     (is_branch),
        .is_jalr_o       (is_jalr),
        .branch_offset_o (branch_offset),
        .rs1_value_o     (rs1_value),
        .rs2_value_o     (rs2_value),
        .ex_pc_o         (ex_pc),
        .ex_rd_o         (ex_rd),
        .ex_reg_write_o  (ex_reg_write)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (rf_we),
        .rd_i       (rf_rd),
        .wd_i       (rf_wd),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    alu u_alu (
        .alu_op_i    (alu_op),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .result_o    (alu_result)
    );

    branch_tester u_branch_tester (
        .branch_cond_i   (branch_cond),
        .rs1_value_i     (rs1_value),
        .rs2_value_i     (rs2_value),
        .pc_i            (ex_pc),
        .branch_offset_i (branch_offset),
        .taken_o         (branch_taken),
        .target_o        (branch_target)
    );

    writeback u_writeback (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .ex_valid_i      (ex_valid),
        .is_branch_i     (is_branch),
        .is_jalr_i       (is_jalr),
        .ex_rd_i         (ex_rd),
        .ex_reg_write_i  (ex_reg_write),
        .ex_pc_i         (ex_pc),
        .alu_result_i    (alu_result),
        .taken_i         (branch_taken),
        .branch_target_i (branch_target),
        .rf_we_o         (rf_we),
        .rf_rd_o         (rf_rd),
        .rf_wd_o         (rf_wd),
        .wb_valid_o      (wb_valid_o),
        .wb_we_o         (wb_we_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .jump_o          (jump_o),
        .jump_target_o   (jump_target_o)
    );

endmodule

// File: verif/core_properties.sv
// concurrent assertions on writeback latency and output consistency of the core
`timescale 1ns/1ps

module core_properties (
    input logic       clk_i,
    input logic       rst_i,
    input logic       instr_valid_i,
    input logic       wb_valid_i,
    input logic       wb_we_i,
    input logic [4:0] wb_rd_i,
    input logic       jump_i
);

    int fail_count = 0; // failed assertion count

    // fixed latency of two cycles, both ways
    strobe_gives_wb: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_valid_i |-> ##2 wb_valid_i)
    else begin
        $error("instruction strobe without a writeback two cycles later");
        fail_count++;
    end

    wb_has_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_valid_i |-> $past(instr_valid_i, 2))
    else begin
        $error("writeback without an instruction strobe two cycles earlier");
        fail_count++;
    end

    we_in_wb: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_we_i |-> wb_valid_i)
    else begin
        $error("register write outside a writeback");
        fail_count++;
    end

    jump_in_wb: assert property (@(posedge clk_i) disable iff (rst_i)
        jump_i |-> wb_valid_i)
    else begin
        $error("jump request outside a writeback");
        fail_count++;
    end

    no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_we_i |-> wb_rd_i != 5'd0)
    else begin
        $error("register write aimed at x0");
        fail_count++;
    end

endmodule

// File: verif/core_checker.sv
// writeback checker, pairs each writeback pulse with its line of the test file
`timescale 1ns/1ps
`include "core_params.svh"

module core_checker (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 wb_valid_i,
    input  logic                 wb_we_i,
    input  logic [4:0]           wb_rd_i,
    input  logic [`XLEN-1:0]     wb_data_i,
    input  logic                 jump_i,
    input  logic [`PC_WIDTH-1:0] jump_target_i,
    output int                   checked_o,
    output int                   failed_o,
    output logic                 done_o
);

    localparam int FIELDS    = 7;
    localparam int MAX_TESTS = 64;

    logic [31:0] test_mem [1 + FIELDS * MAX_TESTS];
    int          n_tests   = 0;
    int          n_checked = 0;
    int          n_failed  = 0;
    int          base;
    bit          ok;

    initial begin
        $readmemh("verif/core_tests.txt", test_mem);
        n_tests = test_mem[0];
    end

    assign checked_o = n_checked;
    assign failed_o  = n_failed;
    assign done_o    = (n_tests > 0) && (n_checked >= n_tests);

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            ok = 1'b0;
        end
    endtask

    // registered outputs are steady at the falling edge
    always @(negedge clk_i) begin
        if (!rst_i && wb_valid_i) begin
            if (n_checked >= n_tests) begin
                $display("unexpected writeback at %0t ns with no test left to match it", $time);
                n_failed = n_failed + 1;
            end else begin
                base = 1 + FIELDS * n_checked;
                ok   = 1'b1;
                compare_field("wb_we_o", 32'(test_mem[base + 2][0]), 32'(wb_we_i));
                compare_field("jump_o", 32'(test_mem[base + 5][0]), 32'(jump_i));
                if (test_mem[base + 2][0]) begin // rd and data only matter on a write
                    compare_field("wb_rd_o", 32'(test_mem[base + 3][4:0]), 32'(wb_rd_i));
                    compare_field("wb_data_o", test_mem[base + 4], wb_data_i);
                end
                if (test_mem[base + 5][0]) begin
                    compare_field("jump_target_o", 32'(test_mem[base + 6][`PC_WIDTH-1:0]),
                                  32'(jump_target_i));
                end
                $display("test %0d instr %h pc %h: %s", n_checked + 1, test_mem[base],
                         test_mem[base + 1][`PC_WIDTH-1:0], ok ? "pass" : "fail");
                if (!ok)
                    n_failed = n_failed + 1;
                n_checked = n_checked + 1;
            end
        end
    end

endmodule

// File: verif/core_tb.sv
// testbench top with clock, reset, stimulus from the test file and run timeout
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;

    localparam int FIELDS    = 7; // instr pc we rd data jump target
    localparam int MAX_TESTS = 64;

    logic                 clk;
    logic                 rst;
    logic                 instr_valid;
    logic [31:0]          instr;
    logic [`PC_WIDTH-1:0] pc;

    logic                 wb_valid;
    logic                 wb_we;
    logic [4:0]           wb_rd;
    logic [`XLEN-1:0]     wb_data;
    logic                 jump;
    logic [`PC_WIDTH-1:0] jump_target;

    int                   checked;
    int                   failed;
    logic                 tests_done;

    logic [31:0]          test_mem [1 + FIELDS * MAX_TESTS];
    int                   n_tests;
    int                   seed;
    int                   gap;
    int                   cycle_count = 0;
    int                   cycle_limit;
    int                   assert_fails;
    logic [31:0]          cur_instr;
    logic [4:0]           prev_rd;

    core_top u_core_top (
        .clk_i         (clk),
        .rst_i         (rst),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .wb_valid_o    (wb_valid),
        .wb_we_o       (wb_we),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .jump_o        (jump),
        .jump_target_o (jump_target)
    );

    core_checker u_core_checker (
        .clk_i         (clk),
        .rst_i         (rst),
        .wb_valid_i    (wb_valid),
        .wb_we_i       (wb_we),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .jump_i        (jump),
        .jump_target_i (jump_target),
        .checked_o     (checked),
        .failed_o      (failed),
        .done_o        (tests_done)
    );

    bind core_top core_properties u_core_properties (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .wb_valid_i    (wb_valid_o),
        .wb_we_i       (wb_we_o),
        .wb_rd_i       (wb_rd_o),
        .jump_i        (jump_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        seed        = 32'h2a3b;
        prev_rd     = '0;
        $readmemh("verif/core_tests.txt", test_mem);
        n_tests     = test_mem[0];
        cycle_limit = 16 + n_tests * 6 + 20; // reset, worst gap plus latency, margin

        repeat (16) @(negedge clk);
        rst = 1'b0;

        for (int k = 0; k < n_tests; k++) begin
            cur_instr = test_mem[1 + FIELDS * k];
            if (k > 0) begin
                // a reader of the previous rd goes back to back, through the bypass
                if (prev_rd != 5'd0 && (cur_instr[19:15] == prev_rd ||
                                        cur_instr[24:20] == prev_rd))
                    gap = 0;
                else
                    gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(negedge clk);
            end
            instr_valid = 1'b1;
            instr       = cur_instr;
            pc          = test_mem[2 + FIELDS * k][`PC_WIDTH-1:0];
            @(negedge clk);
            instr_valid = 1'b0;
            prev_rd     = cur_instr[11:7];
        end

        while (!tests_done && cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        @(negedge clk); // last assertions settle

        assert_fails = u_core_top.u_core_properties.fail_count;
        if (!tests_done) begin
            $display("timeout after %0d cycles, writebacks missing, %0d of %0d arrived",
                     cycle_count, checked, n_tests);
            $display("TESTBENCH FAILED");
        end else begin
            $display("%0d tests checked, %0d failed, %0d assertion failures",
                     checked, failed, assert_fails);
            if (failed == 0 && assert_fails == 0)
                $display("TESTBENCH PASSED");
            else
                $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verif/core_tests.txt
// first value: number of tests, then one test per line
// instr pc we rd data jump target, all hex, rd/data only checked when we=1, target when jump=1
0000002a
// addi chain from reset, x1=5 x2=2 x3=-8 x4=-16, one write to x0
00500093 0000 1 01 00000005 0 0000
ffd08113 0004 1 02 00000002 0 0000
00708013 0008 0 00 00000000 0 0000
ff800193 000c 1 03 fffffff8 0 0000
ff818213 0010 1 04 fffffff0 0 0000
// op: add sub sll slt sltu xor srl sra or and
002082b3 0014 1 05 00000007 0 0000
40110333 0018 1 06 fffffffd 0 0000
002093b3 001c 1 07 00000014 0 0000
0011a433 0020 1 08 00000001 0 0000
0011b4b3 0024 1 09 00000000 0 0000
0030c533 0028 1 0a fffffffd 0 0000
002255b3 002c 1 0b 3ffffffc 0 0000
40225633 0030 1 0c fffffffc 0 0000
0020e6b3 0034 1 0d 00000007 0 0000
00327733 0038 1 0e fffffff0 0 0000
// dependent chain, back to back through the bypass, plus op-imm forms
12300793 003c 1 0f 00000123 0 0000
00f78833 0040 1 10 00000246 0 0000
fff84893 0044 1 11 fffffdb9 0 0000
4048d913 0048 1 12 ffffffdb 0 0000
00092993 004c 1 13 00000001 0 0000
01c95a13 0050 1 14 0000000f 0 0000
00309a93 0054 1 15 00000028 0 0000
7f006b13 0058 1 16 000007f0 0 0000
0ff27b93 005c 1 17 000000f0 0 0000
fff0bc13 0060 1 18 00000001 0 0000
// branches, taken then not taken for each condition
00108863 0100 0 00 00000000 1 0110
00208863 0104 0 00 00000000 0 0000
fe209ce3 0108 0 00 00000000 1 0100
00109863 010c 0 00 00000000 0 0000
0011c863 0110 0 00 00000000 1 0120
0030c863 0114 0 00 00000000 0 0000
fe30dce3 0118 0 00 00000000 1 0110
00325863 011c 0 00 00000000 0 0000
0030e863 0120 0 00 00000000 1 0130
0011e863 0124 0 00 00000000 0 0000
fe11fce3 0128 0 00 00000000 1 0120
0030f863 012c 0 00 00000000 0 0000
// jalr with link, jalr to x0, lui as an unsupported opcode, then readbacks
01078ce7 0200 1 19 00000204 1 0132
fff08067 0300 0 00 00000000 1 0004
000010b7 0400 0 00 00000000 0 0000
00008d13 0404 1 1a 00000005 0 0000
000c8db3 0408 1 1b 00000204 0 0000

// File: all.f
+incdir+include
source/core_pkg.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/branch_tester.sv
source/writeback.sv
source/core_top.sv
verif/core_properties.sv
verif/core_checker.sv
verif/core_tb.sv

// File: Makefile
# Verilator build and run for the core testbench
SIM = obj_dir/Vcore_tb

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module core_tb -f all.f -o Vcore_tb

run: compile
	$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
